/* design/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0]  lc3b_word;
    typedef logic [127:0] lc3b_line;        // Eight words, word 0 in the low bits.
    typedef logic [11:0]  lc3b_line_addr;   // PC bits 15 to 4.
    typedef logic [15:0]  lc3b_byte_sel;    // One enable per byte of a line.
    typedef logic [2:0]   lc3b_word_idx;    // Word position inside a line.

    typedef enum logic [1:0] {
        PC_PLUS2,
        PC_ALU,
        PC_PCN,
        PC_MDR
    } lc3b_pc_mux_sel;

    // Master to slave signals of the instruction bus.
    typedef struct packed {
        lc3b_line_addr adr;
        logic          cyc;
        logic          stb;
        logic          we;
        lc3b_byte_sel  sel;
        lc3b_line      dat_m;
    } wb_master_t;

    // Slave to master signals of the instruction bus.
    typedef struct packed {
        lc3b_line dat_s;
        logic     ack;
        logic     rty;
    } wb_slave_t;

    typedef struct packed {
        logic active;                       // Request is asserted this cycle.
        logic exclusive;
        logic barrier_IF_ID_stall;
        logic barrier_ID_EX_stall;
        logic barrier_EX_MEM_stall;
        logic barrier_MEM_WB_stall;
        logic barrier_IF_ID_reset;
        logic barrier_ID_EX_reset;
        logic barrier_EX_MEM_reset;
        logic barrier_MEM_WB_reset;
        logic barrier_ID_EX_force_sr1_load;
        logic barrier_ID_EX_force_sr2_load;
        logic stage_IF_stall;
        logic stage_ID_stall;
        logic stage_EX_stall;
        logic stage_MEM_stall;
        logic stage_WB_stall;
    } lc3b_pipeline_control_word;

    // Contents of the IF/ID pipeline register.
    typedef struct packed {
        lc3b_word ir;
        lc3b_word pc_plus2;
        logic     valid;
    } if_id_t;

    localparam int MEM_WAIT_CYCLES = 2;     // Stable cycles before the memory acks.
    localparam int MEM_COUNT_W     = $clog2(MEM_WAIT_CYCLES + 1);
    localparam logic [MEM_COUNT_W-1:0] MEM_WAIT_COUNT = MEM_COUNT_W'(MEM_WAIT_CYCLES);
    localparam int MEM_LINES       = 2 ** $bits(lc3b_line_addr);

    localparam lc3b_word PC_RESET  = 16'h0000;
    localparam lc3b_word PC_STEP   = 16'h0002;

    localparam lc3b_pipeline_control_word CONTROL_IDLE = '0;

endpackage : lc3b_pkg

`default_nettype wire

/* design/stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_if
    import lc3b_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_stall,
    input  lc3b_pc_mux_sel            i_pc_mux_sel,
    input  lc3b_word                  i_alu,
    input  lc3b_word                  i_mdr,
    input  lc3b_word                  i_pcn,
    input  wb_slave_t                 i_wb_s,

    output wb_master_t                o_wb_m,
    output lc3b_word                  o_ir,
    output lc3b_word                  o_pc_plus2,
    output lc3b_pipeline_control_word o_request
);

    lc3b_word     pc;
    lc3b_word     pc_next;
    lc3b_word_idx word_idx;
    lc3b_byte_sel byte_sel;
    logic         fetch_wait;

    assign o_pc_plus2 = pc + PC_STEP;
    assign word_idx   = pc[3:1];

    always_comb begin
        case (i_pc_mux_sel)
            PC_PLUS2: pc_next = o_pc_plus2;
            PC_ALU:   pc_next = i_alu;
            PC_PCN:   pc_next = i_pcn;
            PC_MDR:   pc_next = i_mdr;
            default:  pc_next = o_pc_plus2;
        endcase
    end

    // The PC only moves once the current word has been delivered.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc <= PC_RESET;
        end else if (!(i_stall || fetch_wait)) begin
            pc <= pc_next;
        end
    end

    assign byte_sel = 16'h0003 << {word_idx, 1'b0};   // Two bytes of the addressed word.

    assign o_wb_m = '{
        adr:   pc[15:4],
        cyc:   1'b1,
        stb:   1'b1,
        we:    1'b0,
        sel:   byte_sel,
        dat_m: '0
    };

    assign o_ir = i_wb_s.dat_s[{word_idx, 4'b0000} +: 16];

    assign fetch_wait = o_wb_m.cyc & (~i_wb_s.ack | i_wb_s.rty);

    // While waiting on memory everything behind fetch holds still.
    assign o_request = '{
        active:                       fetch_wait,
        exclusive:                    1'b1,
        barrier_IF_ID_stall:          1'b1,
        barrier_ID_EX_stall:          1'b1,
        barrier_EX_MEM_stall:         1'b1,
        barrier_MEM_WB_stall:         1'b1,
        barrier_IF_ID_reset:          1'b0,
        barrier_ID_EX_reset:          1'b0,
        barrier_EX_MEM_reset:         1'b0,
        barrier_MEM_WB_reset:         1'b0,
        barrier_ID_EX_force_sr1_load: 1'b0,
        barrier_ID_EX_force_sr2_load: 1'b0,
        stage_IF_stall:               1'b0,
        stage_ID_stall:               1'b1,
        stage_EX_stall:               1'b1,
        stage_MEM_stall:              1'b1,
        stage_WB_stall:               1'b1
    };

    // Word fetches need an even PC, whatever source loaded it.
    a_pc_even : assert property (@(posedge clk) disable iff (!i_rst_n) !pc[0])
        else $error("stage_if: odd PC %h", pc);

endmodule : stage_if

`default_nettype wire

/* design/line_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module line_memory
    import lc3b_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,
    input  wb_master_t    i_wb_m,
    input  logic          i_load_en,
    input  lc3b_line_addr i_load_addr,
    input  lc3b_line      i_load_line,

    output wb_slave_t     o_wb_s
);

    lc3b_line mem [MEM_LINES];

    lc3b_line_addr          last_adr;
    lc3b_byte_sel           last_sel;
    logic [MEM_COUNT_W-1:0] count;
    logic [MEM_COUNT_W-1:0] count_next;
    logic                   ack_q;
    logic                   bus_req;
    logic                   same_req;

    // Writes from the bus are never served, only reads.
    assign bus_req  = i_wb_m.cyc & i_wb_m.stb & ~i_wb_m.we;
    assign same_req = (i_wb_m.adr == last_adr) && (i_wb_m.sel == last_sel);

    always_ff @(posedge clk) begin
        if (i_load_en) begin
            mem[i_load_addr] <= i_load_line;
        end
    end

    // A new word restarts the count, a held word saturates it.
    always_comb begin
        if (!same_req) begin
            count_next = MEM_COUNT_W'(1);
        end else if (count == MEM_WAIT_COUNT) begin
            count_next = count;
        end else begin
            count_next = count + MEM_COUNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            last_adr <= '0;
            last_sel <= '0;
            count    <= '0;
            ack_q    <= 1'b0;
        end else if (!bus_req) begin
            count    <= '0;
            ack_q    <= 1'b0;
        end else begin
            last_adr <= i_wb_m.adr;
            last_sel <= i_wb_m.sel;
            count    <= count_next;
            ack_q    <= (count_next == MEM_WAIT_COUNT);
        end
    end

    // The registered ack is dropped in the first cycle of a new address.
    assign o_wb_s = '{
        dat_s: mem[i_wb_m.adr],
        ack:   ack_q & same_req & bus_req,
        rty:   1'b0
    };

    // An ack needs the same word requested over the whole wait.
    a_ack_held_request : assert property (@(posedge clk) disable iff (!i_rst_n)
        o_wb_s.ack |-> (i_wb_m.cyc && i_wb_m.stb
                        && $past(bus_req, MEM_WAIT_CYCLES)
                        && i_wb_m.adr == $past(i_wb_m.adr, MEM_WAIT_CYCLES)
                        && i_wb_m.sel == $past(i_wb_m.sel, MEM_WAIT_CYCLES)))
        else $error("line_memory: ack without a held request");

    a_no_write_ack : assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_wb_m.cyc && i_wb_m.stb && i_wb_m.we) |-> !o_wb_s.ack)
        else $error("line_memory: write request acknowledged");

endmodule : line_memory

`default_nettype wire

/* design/pipeline_control_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_control_arbiter
    import lc3b_pkg::*;
(
    input  logic                      clk,
    input  lc3b_pipeline_control_word i_if_request,
    input  lc3b_pipeline_control_word i_ext_request,

    output lc3b_pipeline_control_word o_control
);

    logic ext_win;
    logic if_win;

    // Later stages outrank fetch.
    assign ext_win = i_ext_request.active;
    assign if_win  = ~ext_win & i_if_request.active;

    always_comb begin
        if (ext_win) begin
            o_control = i_ext_request;
        end else if (if_win) begin
            o_control = i_if_request;
        end else begin
            o_control = CONTROL_IDLE;   // Nothing asked, so nothing stalls.
        end
    end

    a_idle_when_inactive : assert property (@(posedge clk)
        !o_control.active |-> (o_control == CONTROL_IDLE))
        else $error("pipeline_control_arbiter: stale fields on an inactive control word");

endmodule : pipeline_control_arbiter

`default_nettype wire

/* design/barrier_if_id.sv */
`timescale 1ns/1ps
`default_nettype none

module barrier_if_id
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_stall,
    input  logic     i_flush,
    input  lc3b_word i_ir,
    input  lc3b_word i_pc_plus2,

    output if_id_t   o_id
);

    lc3b_word ir_q;
    lc3b_word pc_plus2_q;
    logic     valid_q;

    // Flush beats stall so a held bubble can still be cleared.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end else if (!i_stall) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            ir_q       <= i_ir;
            pc_plus2_q <= i_pc_plus2;
        end
    end

    assign o_id = '{
        ir:       ir_q,
        pc_plus2: pc_plus2_q,
        valid:    valid_q
    };

endmodule : barrier_if_id

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import lc3b_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_stall,
    input  lc3b_pc_mux_sel            i_pc_mux_sel,
    input  lc3b_word                  i_alu,
    input  lc3b_word                  i_mdr,
    input  lc3b_word                  i_pcn,
    input  lc3b_pipeline_control_word i_ext_request,
    input  logic                      i_load_en,
    input  lc3b_line_addr             i_load_addr,
    input  lc3b_line                  i_load_line,

    output if_id_t                    o_id,
    output lc3b_pipeline_control_word o_control
);

    wb_master_t                wb_m;
    wb_slave_t                 wb_s;
    lc3b_word                  if_ir;
    lc3b_word                  if_pc_plus2;
    lc3b_pipeline_control_word if_request;
    logic                      if_stall;
    logic                      if_id_stall;

    assign if_stall    = i_stall | o_control.stage_IF_stall;
    assign if_id_stall = i_stall | o_control.barrier_IF_ID_stall;

    stage_if u_stage_if (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_stall      (if_stall),
        .i_pc_mux_sel (i_pc_mux_sel),
        .i_alu        (i_alu),
        .i_mdr        (i_mdr),
        .i_pcn        (i_pcn),
        .i_wb_s       (wb_s),
        .o_wb_m       (wb_m),
        .o_ir         (if_ir),
        .o_pc_plus2   (if_pc_plus2),
        .o_request    (if_request)
    );

    line_memory u_line_memory (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_wb_m      (wb_m),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_line (i_load_line),
        .o_wb_s      (wb_s)
    );

    pipeline_control_arbiter u_arbiter (
        .clk           (clk),
        .i_if_request  (if_request),
        .i_ext_request (i_ext_request),
        .o_control     (o_control)
    );

    // Flush comes only from the later stages.
    barrier_if_id u_barrier_if_id (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (if_id_stall),
        .i_flush    (o_control.barrier_IF_ID_reset),
        .i_ir       (if_ir),
        .i_pc_plus2 (if_pc_plus2),
        .o_id       (o_id)
    );

endmodule : fetch_top

`default_nettype wire

/* tb/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
    import lc3b_pkg::*;
();

    localparam int UPDATE_TIMEOUT = 20;     // Cycles allowed between two IF/ID updates.

    logic                      clk = 1'b0;
    logic                      i_rst_n;
    logic                      i_stall;
    lc3b_pc_mux_sel            i_pc_mux_sel;
    lc3b_word                  i_alu;
    lc3b_word                  i_mdr;
    lc3b_word                  i_pcn;
    lc3b_pipeline_control_word i_ext_request;
    logic                      i_load_en;
    lc3b_line_addr             i_load_addr;
    lc3b_line                  i_load_line;
    if_id_t                    o_id;
    lc3b_pipeline_control_word o_control;

    lc3b_line    image [MEM_LINES];         // What the memory should hold.
    logic [15:0] lfsr;
    lc3b_word    exp_pc;                    // PC of the word now being fetched.
    if_id_t      shown_id;                  // What o_id should show right now.
    int          errors;

    fetch_top dut0 (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_pc_mux_sel  (i_pc_mux_sel),
        .i_alu         (i_alu),
        .i_mdr         (i_mdr),
        .i_pcn         (i_pcn),
        .i_ext_request (i_ext_request),
        .i_load_en     (i_load_en),
        .i_load_addr   (i_load_addr),
        .i_load_line   (i_load_line),
        .o_id          (o_id),
        .o_control     (o_control)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1.
    endfunction

    function automatic lc3b_word random_word();
        lc3b_word w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[14:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic lc3b_line random_line();
        lc3b_line l;
        for (int k = 0; k < 8; k++) begin
            l[16 * k +: 16] = random_word();
        end
        return l;
    endfunction

    function automatic lc3b_word random_target();
        lc3b_word t;
        t = random_word() & 16'hFFFE;
        if (t == exp_pc) begin
            t = t ^ 16'h0010;               // Keeps the next two updates distinct.
        end
        return t;
    endfunction

    // Word k of a line sits in bits 16k+15 down to 16k.
    function automatic if_id_t expected_fetch(input lc3b_word pc, input lc3b_line line);
        if_id_t r;
        r.ir       = line[16 * int'(pc[3:1]) +: 16];
        r.pc_plus2 = pc + 16'd2;
        r.valid    = 1'b1;
        return r;
    endfunction

    function automatic lc3b_word next_pc(input lc3b_word pc);
        case (i_pc_mux_sel)
            PC_ALU:  return i_alu;
            PC_PCN:  return i_pcn;
            PC_MDR:  return i_mdr;
            default: return pc + 16'd2;
        endcase
    endfunction

    function automatic lc3b_pipeline_control_word fetch_request();
        lc3b_pipeline_control_word c;
        c = CONTROL_IDLE;
        c.active               = 1'b1;
        c.exclusive            = 1'b1;
        c.barrier_IF_ID_stall  = 1'b1;
        c.barrier_ID_EX_stall  = 1'b1;
        c.barrier_EX_MEM_stall = 1'b1;
        c.barrier_MEM_WB_stall = 1'b1;
        c.stage_ID_stall       = 1'b1;
        c.stage_EX_stall       = 1'b1;
        c.stage_MEM_stall      = 1'b1;
        c.stage_WB_stall       = 1'b1;
        return c;
    endfunction

    task automatic stop_on_failure();
        errors++;
        $display("Some tests failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_id(input string name, input if_id_t got, input if_id_t want);
        if (got !== want) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            stop_on_failure();
        end
    endtask

    task automatic check_control(input string name, input lc3b_pipeline_control_word got,
                                 input lc3b_pipeline_control_word want);
        if (got !== want) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, want);
            stop_on_failure();
        end
    endtask

    task automatic load_line(input lc3b_line_addr addr, input lc3b_line line);
        @(posedge clk);
        i_load_en   <= 1'b1;
        i_load_addr <= addr;
        i_load_line <= line;
        image[addr] = line;
        @(posedge clk);
        i_load_en   <= 1'b0;
    endtask

    task automatic wait_update(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > UPDATE_TIMEOUT) begin
                $display("timeout: o_id did not update within %0d cycles", UPDATE_TIMEOUT);
                stop_on_failure();
            end
        end while (o_id === shown_id);
    endtask

    task automatic fetch_and_check(input logic timed);
        int     cycles;
        if_id_t want;
        wait_update(cycles);
        want = expected_fetch(exp_pc, image[exp_pc[15:4]]);
        check_id("o_id", o_id, want);
        if (timed && cycles != MEM_WAIT_CYCLES + 1) begin
            $display("error at %0t ns: update interval is %0d cycles, expected %0d",
                     $time, cycles, MEM_WAIT_CYCLES + 1);
            stop_on_failure();
        end
        shown_id = want;
        exp_pc   = next_pc(exp_pc);         // Select in effect at the capture edge.
    endtask

    // The word already in flight lands first, then the redirected one.
    task automatic redirect_and_check(input lc3b_pc_mux_sel sel, input lc3b_word target);
        @(posedge clk);
        i_pc_mux_sel <= sel;
        i_alu        <= (sel == PC_ALU) ? target : random_word();
        i_pcn        <= (sel == PC_PCN) ? target : random_word();
        i_mdr        <= (sel == PC_MDR) ? target : random_word();
        fetch_and_check(1'b1);
        @(posedge clk);
        i_pc_mux_sel <= PC_PLUS2;
        fetch_and_check(1'b1);
    endtask

    task automatic hold_and_check(input logic use_ext, input int n);
        lc3b_pipeline_control_word req;
        req = CONTROL_IDLE;
        req.active              = 1'b1;
        req.barrier_IF_ID_stall = 1'b1;
        req.barrier_ID_EX_stall = 1'b1;
        req.stage_IF_stall      = 1'b1;
        req.stage_ID_stall      = 1'b1;
        @(posedge clk);
        if (use_ext) begin
            i_ext_request <= req;
        end else begin
            i_stall <= 1'b1;
        end
        repeat (n) begin
            @(negedge clk);
            check_id("o_id", o_id, shown_id);
            if (use_ext) begin
                check_control("o_control", o_control, req);
            end
        end
        @(posedge clk);
        i_ext_request <= CONTROL_IDLE;
        i_stall       <= 1'b0;
    endtask

    task automatic flush_and_check();
        lc3b_pipeline_control_word req;
        if_id_t                    flushed;
        req = CONTROL_IDLE;
        req.active              = 1'b1;
        req.barrier_IF_ID_reset = 1'b1;
        req.barrier_IF_ID_stall = 1'b1;
        req.stage_IF_stall      = 1'b1;
        @(posedge clk);
        i_ext_request <= req;
        @(posedge clk);
        i_ext_request <= CONTROL_IDLE;
        @(negedge clk);
        flushed       = shown_id;
        flushed.valid = 1'b0;
        check_id("o_id", o_id, flushed);
        shown_id = flushed;
    endtask

    // Every word of line 0 gets a new value, so a stale line cannot match.
    task automatic reload_and_check();
        lc3b_line fresh;
        lc3b_word r;
        lc3b_word target;
        fresh = random_line();
        for (int k = 0; k < 8; k++) begin
            if (fresh[16 * k +: 16] == image[0][16 * k +: 16]) begin
                fresh[16 * k +: 16] = ~fresh[16 * k +: 16];
            end
        end
        load_line(12'h000, fresh);
        fetch_and_check(1'b0);
        r      = random_word();
        target = {12'h000, r[3:1], 1'b0};
        if (target == exp_pc) begin
            target = target ^ 16'h0002;
        end
        redirect_and_check(PC_PCN, target);
    endtask

    initial begin
        errors        = 0;
        lfsr          = 16'd25;
        i_rst_n       = 1'b0;
        i_stall       = 1'b1;                // PC waits until the image is loaded.
        i_pc_mux_sel  = PC_PLUS2;
        i_alu         = '0;
        i_mdr         = '0;
        i_pcn         = '0;
        i_ext_request = CONTROL_IDLE;
        i_load_en     = 1'b0;
        i_load_addr   = '0;
        i_load_line   = '0;
        exp_pc        = PC_RESET;

        repeat (10) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_flag("o_id.valid", o_id.valid, 1'b0);
        check_control("o_control", o_control, fetch_request());
        shown_id = o_id;

        for (int a = 0; a < MEM_LINES; a++) begin
            load_line(lc3b_line_addr'(a), random_line());
        end
        @(posedge clk);
        i_stall <= 1'b0;

        fetch_and_check(1'b0);
        repeat (15) fetch_and_check(1'b1);

        redirect_and_check(PC_ALU, random_target());
        redirect_and_check(PC_PCN, random_target());
        redirect_and_check(PC_MDR, random_target());

        hold_and_check(1'b0, 8);
        fetch_and_check(1'b0);
        hold_and_check(1'b1, 8);
        fetch_and_check(1'b0);

        flush_and_check();
        fetch_and_check(1'b0);

        reload_and_check();
        repeat (4) fetch_and_check(1'b1);

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : fetch_tb

`default_nettype wire

/* list.f */
design/lc3b_pkg.sv
design/stage_if.sv
design/line_memory.sv
design/pipeline_control_arbiter.sv
design/barrier_if_id.sv
design/fetch_top.sv
tb/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --assert --timescale 1ns/1ps --top-module fetch_tb \
        -f list.f -o fetch_sim \
    && ./obj_dir/fetch_sim | tee /dev/stderr | grep "All tests passed" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
